// File: list.f
hw/csr_map_pkg.sv
hw/trap_pkg.sv
hw/perf_counters.sv
hw/trap_ctrl.sv
hw/csr_regfile.sv
hw/csr_unit.sv
bench/csr_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= csr_unit_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '** FAIL **' $(LOG) || ! grep -qF '** PASS **' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/csr_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb;
    import csr_map_pkg::*;
    import trap_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int BUDGET_CYCLES = RESET_CYCLES + 20 + 100 + 60 + 25 + 30 + 15; // Per-test sum.

    logic        clk;
    logic        rst_n;
    logic        csr_wr_en;
    logic [2:0]  func3;
    logic [4:0]  csr_imm;
    logic [11:0] csr_addr;
    logic [31:0] csr_wdata;
    logic [31:0] csr_rdata;
    logic        illegal_insn;
    logic        fetch_fault;
    logic        insn_finished;
    logic        mret;
    logic [31:0] fetch_pc;
    logic [31:0] decode_pc;
    logic        ext_irq;
    logic        ifid_flush;
    logic        idex_flush;
    logic        exmem_flush;
    logic [31:0] trap_pc;

    // Reference model state.
    logic        chk_rdata;
    logic [31:0] exp_rdata;
    logic        exp_flush;
    logic [31:0] exp_pc;
    logic [31:0] sh_mscratch;
    logic [31:0] sh_mtvec;
    logic [31:0] sh_mepc;
    logic [31:0] sh_mcause;
    logic [31:0] sh_mstatus;
    logic [31:0] lcg_state;
    logic [31:0] r;
    logic [31:0] opnd;
    logic [31:0] count0;
    logic [31:0] pulses;
    logic [31:0] vbase;
    logic [2:0]  f3;
    int          k;
    int          errors;
    int          errors_at_start;
    int          test_num;
    int          tests_failed;

    csr_unit u_dut (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .csr_wr_en_i            (csr_wr_en),
        .func3_i                (func3),
        .csr_imm_i              (csr_imm),
        .csr_addr_i             (csr_addr),
        .csr_wdata_i            (csr_wdata),
        .csr_rdata_o            (csr_rdata),
        .illegal_insn_i         (illegal_insn),
        .fetch_fault_i          (fetch_fault),
        .instruction_finished_i (insn_finished),
        .mret_i                 (mret),
        .fetch_pc_i             (fetch_pc),
        .decode_pc_i            (decode_pc),
        .external_irq_i         (ext_irq),
        .ifid_flush_o           (ifid_flush),
        .idex_flush_o           (idex_flush),
        .exmem_flush_o          (exmem_flush),
        .trap_pc_o              (trap_pc)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
        chk_rdata |-> (csr_rdata == exp_rdata))
        else begin
            $display("mismatch csr_rdata_o at addr %h: expected %h, got %h",
                $sampled(csr_addr), $sampled(exp_rdata), $sampled(csr_rdata));
            errors++;
        end

    // All three stages flush together, and only when the model says so.
    a_flush: assert property (@(posedge clk) disable iff (!rst_n)
        {ifid_flush, idex_flush, exmem_flush} == {3{exp_flush}})
        else begin
            $display("mismatch {ifid,idex,exmem}_flush_o: expected %h, got %h",
                {3{$sampled(exp_flush)}}, $sampled({ifid_flush, idex_flush, exmem_flush}));
            errors++;
        end

    a_trap_pc: assert property (@(posedge clk) disable iff (!rst_n)
        exp_flush |-> (trap_pc == exp_pc))
        else begin
            $display("mismatch trap_pc_o: expected %h, got %h",
                $sampled(exp_pc), $sampled(trap_pc));
            errors++;
        end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Zicsr result on the old value.
    function automatic logic [31:0] apply_csr_op(input logic [31:0] old, input logic [1:0] op,
                                                 input logic [31:0] operand);
        case (op)
            CSR_OP_WRITE: return operand;
            CSR_OP_SET:   return old | operand;
            CSR_OP_CLEAR: return old & ~operand;
            default:      return old;
        endcase
    endfunction

    task automatic csr_op(input logic [11:0] addr, input logic [2:0] fn, input logic [31:0] wd,
                          input logic [4:0] imm, input logic [31:0] exp_old);
        csr_wr_en = 1'b1;
        func3     = fn;
        csr_wdata = wd;
        csr_imm   = imm;
        csr_addr  = addr;
        exp_rdata = exp_old; // Read returns the old value.
        chk_rdata = 1'b1;
        @(negedge clk);
        csr_wr_en = 1'b0;
        chk_rdata = 1'b0;
    endtask

    task automatic csr_read(input logic [11:0] addr, input logic [31:0] expected);
        csr_addr  = addr;
        exp_rdata = expected;
        chk_rdata = 1'b1;
        @(negedge clk);
        chk_rdata = 1'b0;
    endtask

    // Called in the cycle after the cause.
    task automatic expect_flush(input logic [31:0] pc);
        exp_flush = 1'b1;
        exp_pc    = pc;
        @(negedge clk);
        exp_flush = 1'b0;
    endtask

    task automatic end_test(input string name);
        int fails;
        fails = errors - errors_at_start;
        test_num++;
        if (fails != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s (%0d errors)", test_num, name, (fails == 0) ? "ok" : "failed",
            fails);
        errors_at_start = errors;
    endtask

    initial begin
        #(2 * BUDGET_CYCLES * CLK_PERIOD);
        $display("Watchdog expired: run did not finish within %0d cycles", 2 * BUDGET_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        csr_wr_en = 1'b0;
        func3 = 3'd0;
        csr_imm = 5'd0;
        csr_addr = 12'd0;
        csr_wdata = 32'd0;
        illegal_insn = 1'b0;
        fetch_fault = 1'b0;
        insn_finished = 1'b0;
        mret = 1'b0;
        fetch_pc = 32'd0;
        decode_pc = 32'd0;
        ext_irq = 1'b0;
        chk_rdata = 1'b0;
        exp_rdata = 32'd0;
        exp_flush = 1'b0;
        exp_pc = 32'd0;
        sh_mscratch = 32'd0;
        sh_mtvec = 32'd0;
        sh_mepc = 32'd0;
        sh_mcause = 32'd0;
        sh_mstatus = 32'h0000_1800; // MPP fixed at machine mode.
        lcg_state = 32'h9386c06c;
        errors = 0;
        errors_at_start = 0;
        test_num = 0;
        tests_failed = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        csr_read(CSR_MISA, MISA_VALUE);
        csr_read(CSR_MVENDORID, 32'd0);
        csr_read(CSR_MARCHID, 32'd0);
        csr_read(CSR_MIMPID, 32'd0);
        csr_read(CSR_MHARTID, 32'd0);
        csr_read(12'h7C0, 32'd0); // Unmapped.
        csr_read(CSR_TIME, 32'd0);
        csr_read(CSR_MSTATUS, sh_mstatus);
        csr_op(CSR_MISA, 3'b001, 32'd0, 5'd0, MISA_VALUE);
        csr_read(CSR_MISA, MISA_VALUE);
        end_test("identity and read-only registers");

        repeat (40) begin
            r = next_rand();
            f3 = {r[8], 2'(r % 32'd3 + 32'd1)};
            csr_wdata = next_rand();
            opnd = f3[2] ? {27'd0, r[20:16]} : csr_wdata;
            csr_op(CSR_MSCRATCH, f3, csr_wdata, r[20:16], sh_mscratch);
            sh_mscratch = apply_csr_op(sh_mscratch, f3[1:0], opnd);
            csr_read(CSR_MSCRATCH, sh_mscratch);
        end
        end_test("zicsr operations on mscratch");

        csr_addr = CSR_MCYCLE;
        @(negedge clk);
        count0 = csr_rdata;
        k = 3 + int'(next_rand() % 32'd13);
        repeat (k) @(negedge clk);
        csr_read(CSR_MCYCLE, count0 + 32'(k));
        csr_addr = CSR_MINSTRET;
        @(negedge clk);
        count0 = csr_rdata;
        pulses = 32'd0;
        repeat (20) begin
            r = next_rand();
            insn_finished = r[4];
            pulses = pulses + {31'd0, r[4]};
            @(negedge clk);
        end
        insn_finished = 1'b0;
        csr_read(CSR_MINSTRET, count0 + pulses);
        csr_read(CSR_MCYCLEH, 32'd0);
        csr_read(CSR_MINSTRETH, 32'd0);
        csr_read(CSR_CYCLEH, 32'd0);
        end_test("cycle and instret counters");

        r = next_rand() & 32'hFFFF_FFFC;
        csr_op(CSR_MTVEC, 3'b001, r, 5'd0, sh_mtvec);
        sh_mtvec = r;
        csr_op(CSR_MSTATUS, 3'b110, 32'd0, 5'd8, sh_mstatus); // Set MIE by immediate.
        sh_mstatus = sh_mstatus | 32'h0000_0008;
        csr_read(CSR_MSTATUS, sh_mstatus);
        decode_pc = next_rand() & 32'hFFFF_FFFC;
        fetch_pc = next_rand() & 32'hFFFF_FFFC;
        illegal_insn = 1'b1;
        fetch_fault = 1'b1; // Loses to the older instruction.
        @(negedge clk);
        illegal_insn = 1'b0;
        fetch_fault = 1'b0;
        expect_flush(sh_mtvec);
        sh_mepc = decode_pc;
        sh_mcause = 32'd2;
        sh_mstatus = 32'h0000_1880; // MIE moved to MPIE.
        csr_read(CSR_MEPC, sh_mepc);
        csr_read(CSR_MCAUSE, sh_mcause);
        csr_read(CSR_MTVAL, 32'd0);
        csr_read(CSR_MSTATUS, sh_mstatus);
        end_test("illegal instruction trap, direct mode");

        vbase = next_rand() & 32'hFFFF_FFFC;
        csr_op(CSR_MTVEC, 3'b001, vbase | 32'd1, 5'd0, sh_mtvec);
        sh_mtvec = vbase | 32'd1;
        csr_read(CSR_MTVEC, sh_mtvec);
        ext_irq = 1'b1;
        csr_read(CSR_MIP, 32'h0000_0800);
        repeat (3) @(negedge clk); // Enables clear, so no flush.
        csr_op(CSR_MIE, 3'b010, 32'h0000_0800, 5'd0, 32'd0);
        decode_pc = next_rand() & 32'hFFFF_FFFC;
        csr_op(CSR_MSTATUS, 3'b110, 32'd0, 5'd8, sh_mstatus);
        @(negedge clk); // Interrupt is taken in this cycle.
        ext_irq = 1'b0;
        expect_flush(vbase + 32'd44);
        sh_mepc = decode_pc;
        sh_mcause = (32'd1 << 31) | 32'd11;
        sh_mstatus = 32'h0000_1880;
        csr_read(CSR_MCAUSE, sh_mcause);
        csr_read(CSR_MEPC, sh_mepc);
        csr_read(CSR_MSTATUS, sh_mstatus);
        csr_read(CSR_MIP, 32'd0);
        end_test("external interrupt, vectored mode");

        mret = 1'b1;
        @(negedge clk);
        mret = 1'b0;
        expect_flush(sh_mepc);
        sh_mstatus = 32'h0000_1888; // MIE restored, MPIE set.
        csr_read(CSR_MSTATUS, sh_mstatus);
        end_test("mret");

        $display("%0d tests run, %0d failed, %0d errors", test_num, tests_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        csr_wr_en_i,
    input  wire logic [2:0]  func3_i,
    input  wire logic [4:0]  csr_imm_i,
    input  wire logic [11:0] csr_addr_i,
    input  wire logic [31:0] csr_wdata_i,
    output logic [31:0]      csr_rdata_o,
    input  wire logic        illegal_insn_i,
    input  wire logic        fetch_fault_i,
    input  wire logic        instruction_finished_i,
    input  wire logic        mret_i,
    input  wire logic [31:0] fetch_pc_i,
    input  wire logic [31:0] decode_pc_i,
    input  wire logic        external_irq_i,
    output logic             ifid_flush_o,
    output logic             idex_flush_o,
    output logic             exmem_flush_o,
    output logic [31:0]      trap_pc_o
);
    import csr_map_pkg::*;
    import trap_pkg::*;

    csr_req_t    req;
    trap_state_t trap_state;
    trap_event_t trap_evt;
    logic [63:0] cycles;
    logic [63:0] instret;
    logic        flush;

    assign req = '{
        wr_en:   csr_wr_en_i,
        use_imm: func3_i[2],
        op:      csr_op_e'(func3_i[1:0]),
        imm:     csr_imm_i,
        addr:    csr_addr_i,
        wdata:   csr_wdata_i
    };

    csr_regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_i      (req),
        .cycles_i   (cycles),
        .instret_i  (instret),
        .irq_line_i (external_irq_i),
        .event_i    (trap_evt),
        .rdata_o    (csr_rdata_o),
        .state_o    (trap_state)
    );

    perf_counters u_counters (
        .clk       (clk),
        .rst_n     (rst_n),
        .retire_i  (instruction_finished_i),
        .cycles_o  (cycles),
        .instret_o (instret)
    );

    trap_ctrl u_trap (
        .clk            (clk),
        .rst_n          (rst_n),
        .illegal_insn_i (illegal_insn_i),
        .fetch_fault_i  (fetch_fault_i),
        .irq_i          (external_irq_i),
        .mret_i         (mret_i),
        .fetch_pc_i     (fetch_pc_i),
        .decode_pc_i    (decode_pc_i),
        .state_i        (trap_state),
        .event_o        (trap_evt),
        .flush_o        (flush),
        .redirect_pc_o  (trap_pc_o)
    );

    // One pulse clears all three front-end stages.
    assign ifid_flush_o  = flush;
    assign idex_flush_o  = flush;
    assign exmem_flush_o = flush;

endmodule

`default_nettype wire

// File: hw/csr_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module csr_regfile (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire csr_map_pkg::csr_req_t  req_i,
    input  wire logic [63:0]            cycles_i,
    input  wire logic [63:0]            instret_i,
    input  wire logic                   irq_line_i,
    input  wire trap_pkg::trap_event_t  event_i,
    output logic [31:0]                 rdata_o,
    output trap_pkg::trap_state_t       state_o
);
    import csr_map_pkg::*;
    import trap_pkg::*;

    logic        mstatus_mie_q;
    logic        mstatus_mpie_q;
    logic        mie_meie_q;
    logic [31:0] mtvec_q;
    logic [31:0] mscratch_q;
    logic [31:0] mepc_q;
    logic [31:0] mcause_q;
    logic [31:0] mtval_q;

    logic [31:0] mstatus_rd;
    logic [31:0] mie_rd;
    logic [31:0] mip_rd;
    logic [31:0] operand;
    logic [31:0] wr_val;
    logic        do_write;

    // Sparse registers expanded to full words.
    always_comb begin
        mstatus_rd = '0;
        mstatus_rd[MSTATUS_MIE]  = mstatus_mie_q;
        mstatus_rd[MSTATUS_MPIE] = mstatus_mpie_q;
        mstatus_rd[MSTATUS_MPP_LSB +: 2] = 2'b11; // Machine mode only.
        mie_rd = '0;
        mie_rd[MIE_MEIE] = mie_meie_q;
        mip_rd = '0;
        mip_rd[MIP_MEIP] = irq_line_i;
    end

    always_comb begin
        case (req_i.addr)
            CSR_CYCLE, CSR_MCYCLE:       rdata_o = cycles_i[31:0];
            CSR_CYCLEH, CSR_MCYCLEH:     rdata_o = cycles_i[63:32];
            CSR_INSTRET, CSR_MINSTRET:   rdata_o = instret_i[31:0];
            CSR_INSTRETH, CSR_MINSTRETH: rdata_o = instret_i[63:32];
            CSR_TIME, CSR_TIMEH:         rdata_o = '0; // No timer.
            CSR_MISA:                    rdata_o = MISA_VALUE;
            CSR_MVENDORID, CSR_MARCHID,
            CSR_MIMPID, CSR_MHARTID:     rdata_o = '0;
            CSR_MSTATUS:                 rdata_o = mstatus_rd;
            CSR_MIE:                     rdata_o = mie_rd;
            CSR_MIP:                     rdata_o = mip_rd;
            CSR_MTVEC:                   rdata_o = mtvec_q;
            CSR_MSCRATCH:                rdata_o = mscratch_q;
            CSR_MEPC:                    rdata_o = mepc_q;
            CSR_MCAUSE:                  rdata_o = mcause_q;
            CSR_MTVAL:                   rdata_o = mtval_q;
            default:                     rdata_o = '0;
        endcase
    end

    assign operand = req_i.use_imm ? {27'd0, req_i.imm} : req_i.wdata;

    // Read-modify-write on the old value.
    always_comb begin
        case (req_i.op)
            CSR_OP_WRITE: wr_val = operand;
            CSR_OP_SET:   wr_val = rdata_o | operand;
            CSR_OP_CLEAR: wr_val = rdata_o & ~operand;
            default:      wr_val = rdata_o;
        endcase
    end

    assign do_write = req_i.wr_en && (req_i.op != CSR_OP_NONE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mstatus_mie_q  <= 1'b0;
            mstatus_mpie_q <= 1'b0;
            mie_meie_q     <= 1'b0;
            mtvec_q        <= '0;
            mscratch_q     <= '0;
            mepc_q         <= '0;
            mcause_q       <= '0;
            mtval_q        <= '0;
        end else if (event_i.take) begin
            // Push the interrupt-enable stack.
            mstatus_mpie_q <= mstatus_mie_q;
            mstatus_mie_q  <= 1'b0;
            mepc_q         <= {event_i.epc[31:2], 2'b00};
            mcause_q       <= event_i.cause;
            mtval_q        <= event_i.tval;
        end else if (event_i.mret) begin
            mstatus_mie_q  <= mstatus_mpie_q;
            mstatus_mpie_q <= 1'b1;
        end else if (do_write) begin
            case (req_i.addr)
                CSR_MSTATUS: begin
                    mstatus_mie_q  <= wr_val[MSTATUS_MIE];
                    mstatus_mpie_q <= wr_val[MSTATUS_MPIE];
                end
                CSR_MIE:      mie_meie_q <= wr_val[MIE_MEIE];
                // Reserved modes fall back to direct.
                CSR_MTVEC:    mtvec_q <= {wr_val[31:2],
                                  (wr_val[1:0] == MTVEC_VECTORED) ? MTVEC_VECTORED : MTVEC_DIRECT};
                CSR_MSCRATCH: mscratch_q <= wr_val;
                CSR_MEPC:     mepc_q     <= {wr_val[31:2], 2'b00};
                CSR_MCAUSE:   mcause_q   <= wr_val;
                CSR_MTVAL:    mtval_q    <= wr_val;
                default: begin
                end
            endcase
        end
    end

    assign state_o = '{
        mie_global: mstatus_mie_q,
        meie:       mie_meie_q,
        mtvec:      mtvec_q,
        mepc:       mepc_q
    };

    // Trap controller never enters and returns in one cycle.
    assert property (@(posedge clk) disable iff (!rst_n)
        !(event_i.take && event_i.mret));

endmodule

`default_nettype wire

// File: hw/trap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   illegal_insn_i,
    input  wire logic                   fetch_fault_i,
    input  wire logic                   irq_i,
    input  wire logic                   mret_i,
    input  wire logic [31:0]            fetch_pc_i,
    input  wire logic [31:0]            decode_pc_i,
    input  wire trap_pkg::trap_state_t  state_i,
    output trap_pkg::trap_event_t       event_o,
    output logic                        flush_o,
    output logic [31:0]                 redirect_pc_o
);
    import trap_pkg::*;

    logic        irq_pending;
    logic        trap_req;
    logic        take;
    logic        do_mret;
    logic [31:0] cause_sel;
    logic [31:0] epc_sel;
    logic [31:0] tval_sel;
    logic [31:0] mtvec_base;
    logic [31:0] trap_target;

    // Interrupt gated by both enables.
    assign irq_pending = irq_i && state_i.mie_global && state_i.meie;
    assign trap_req    = illegal_insn_i || fetch_fault_i || irq_pending;

    // Nothing new while a flush is on its way out.
    assign take    = trap_req && !flush_o;
    assign do_mret = mret_i && !trap_req && !flush_o;

    // Decode holds the older instruction, so it wins.
    always_comb begin
        if (illegal_insn_i) begin
            cause_sel = CAUSE_ILLEGAL_INSN;
            epc_sel   = decode_pc_i;
            tval_sel  = '0;
        end else if (fetch_fault_i) begin
            cause_sel = CAUSE_FETCH_FAULT;
            epc_sel   = fetch_pc_i;
            tval_sel  = fetch_pc_i; // Faulting address.
        end else begin
            cause_sel = CAUSE_M_EXT_IRQ;
            epc_sel   = decode_pc_i;
            tval_sel  = '0;
        end
    end

    assign mtvec_base = {state_i.mtvec[31:2], 2'b00};

    // Vectored mode offsets interrupts by four times the cause code.
    always_comb begin
        trap_target = mtvec_base;
        if ((state_i.mtvec[1:0] == MTVEC_VECTORED) && cause_sel[31]) begin
            trap_target = mtvec_base + {cause_sel[29:0], 2'b00};
        end
    end

    assign event_o = '{
        take:  take,
        mret:  do_mret,
        cause: cause_sel,
        epc:   epc_sel,
        tval:  tval_sel
    };

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flush_o       <= 1'b0;
            redirect_pc_o <= '0;
        end else begin
            flush_o <= take || do_mret;
            if (take) begin
                redirect_pc_o <= trap_target;
            end else if (do_mret) begin
                redirect_pc_o <= state_i.mepc;
            end
        end
    end

    // Single-cycle pulse, even under back-to-back causes.
    assert property (@(posedge clk) disable iff (!rst_n)
        flush_o |=> !flush_o);

    // Both mtvec base and stored mepc must land on a word.
    assert property (@(posedge clk) disable iff (!rst_n)
        flush_o |-> (redirect_pc_o[1:0] == 2'b00));

endmodule

`default_nettype wire

// File: hw/perf_counters.sv
`timescale 1ns/1ps
`default_nettype none

module perf_counters (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        retire_i,
    output logic [63:0]      cycles_o,
    output logic [63:0]      instret_o
);

    // Free-running counters wide enough to carry across 32 bits.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycles_o  <= '0;
            instret_o <= '0;
        end else begin
            cycles_o <= cycles_o + 64'd1;
            if (retire_i) begin
                instret_o <= instret_o + 64'd1; // At most one per cycle.
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/trap_pkg.sv
`default_nettype none

package trap_pkg;

    localparam logic [31:0] CAUSE_FETCH_FAULT  = 32'd1;
    localparam logic [31:0] CAUSE_ILLEGAL_INSN = 32'd2;
    // Interrupt flag in bit 31, code 11.
    localparam logic [31:0] CAUSE_M_EXT_IRQ    = 32'h8000_000B;

    // mtvec mode field.
    localparam logic [1:0] MTVEC_DIRECT   = 2'd0;
    localparam logic [1:0] MTVEC_VECTORED = 2'd1;

    // Trap controller to register file.
    typedef struct packed {
        logic        take;
        logic        mret;
        logic [31:0] cause;
        logic [31:0] epc;
        logic [31:0] tval;
    } trap_event_t;

    // Register file to trap controller.
    typedef struct packed {
        logic        mie_global; // mstatus.MIE.
        logic        meie;
        logic [31:0] mtvec;
        logic [31:0] mepc;
    } trap_state_t;

endpackage

`default_nettype wire

// File: hw/csr_map_pkg.sv
`default_nettype none

package csr_map_pkg;

    // User-mode counter aliases.
    localparam logic [11:0] CSR_CYCLE     = 12'hC00;
    localparam logic [11:0] CSR_TIME      = 12'hC01;
    localparam logic [11:0] CSR_INSTRET   = 12'hC02;
    localparam logic [11:0] CSR_CYCLEH    = 12'hC80;
    localparam logic [11:0] CSR_TIMEH     = 12'hC81;
    localparam logic [11:0] CSR_INSTRETH  = 12'hC82;

    localparam logic [11:0] CSR_MCYCLE    = 12'hB00;
    localparam logic [11:0] CSR_MINSTRET  = 12'hB02;
    localparam logic [11:0] CSR_MCYCLEH   = 12'hB80;
    localparam logic [11:0] CSR_MINSTRETH = 12'hB82;

    // Identity, all read-only.
    localparam logic [11:0] CSR_MISA      = 12'h301;
    localparam logic [11:0] CSR_MVENDORID = 12'hF11;
    localparam logic [11:0] CSR_MARCHID   = 12'hF12;
    localparam logic [11:0] CSR_MIMPID    = 12'hF13;
    localparam logic [11:0] CSR_MHARTID   = 12'hF14;

    localparam logic [11:0] CSR_MSTATUS   = 12'h300;
    localparam logic [11:0] CSR_MIE       = 12'h304;
    localparam logic [11:0] CSR_MTVEC     = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH  = 12'h340;
    localparam logic [11:0] CSR_MEPC      = 12'h341;
    localparam logic [11:0] CSR_MCAUSE    = 12'h342;
    localparam logic [11:0] CSR_MTVAL     = 12'h343;
    localparam logic [11:0] CSR_MIP       = 12'h344; // Read-only here.

    localparam int MSTATUS_MIE     = 3;
    localparam int MSTATUS_MPIE    = 7;
    localparam int MSTATUS_MPP_LSB = 11; // Two bits wide.
    localparam int MIE_MEIE        = 11;
    localparam int MIP_MEIP        = 11;

    // RV32 with A, C, I and M.
    localparam logic [31:0] MISA_VALUE = 32'h4000_1105;

    // Low two bits of funct3.
    typedef enum logic [1:0] {
        CSR_OP_NONE  = 2'b00,
        CSR_OP_WRITE = 2'b01,
        CSR_OP_SET   = 2'b10,
        CSR_OP_CLEAR = 2'b11
    } csr_op_e;

    typedef struct packed {
        logic        wr_en;
        logic        use_imm; // From funct3 bit 2.
        csr_op_e     op;
        logic [4:0]  imm;
        logic [11:0] addr;
        logic [31:0] wdata;
    } csr_req_t;

endpackage

`default_nettype wire
